//--- src/vga_macros.svh
/*
 * Raster timing, frame-buffer geometry and reset synchronizer depth
 */

`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// ====================
// Horizontal timing, in pixel clocks
// ====================
`define VGA_H_VISIBLE 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_BACK 48
`define VGA_H_TOTAL 800

// ====================
// Vertical timing, in lines
// ====================
`define VGA_V_VISIBLE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_BACK 33
`define VGA_V_TOTAL 525

// Buffer geometry, one word row covers four display lines
`define VGA_WORDS_PER_ROW 80
`define VGA_MEM_WORDS 9600
`define VGA_ADDR_W 14

// Flops in the reset synchronizer
`define VGA_RST_SYNC_STAGES 4

`endif

//--- src/vgaPkg.sv
/*
 * Shared types: core request, colour and sync outputs, raster position
 */

package vgaPkg;

    // Core request into the frame buffer, byte addressed
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] address;
        logic [3:0]  byteEn;
        logic        wrEn;
        logic        rdEn;
    } coreReqT;

    // 4 bits per colour channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // Both pulses are active low
    typedef struct packed {
        logic hSync;
        logic vSync;
    } syncT;

    // Raster state from the sync generator
    // pixelX holds the horizontal count without its low bit
    typedef struct packed {
        syncT       sync;
        logic       inDisplay;
        logic [8:0] pixelX;
        logic [8:0] lineY;
    } rasterT;

endpackage

//--- src/vgaSyncGen.sv
/*
 * Horizontal and line counters with sync and display-area decode
 */

`timescale 1ns/100ps
`include "vga_macros.svh"

module vgaSyncGen
    import vgaPkg::*;
(
    input  logic   clk25,
    input  logic   arstN,
    output rasterT raster
);

    // Decode points
    localparam logic [9:0] HVisible   = 10'(`VGA_H_VISIBLE);
    localparam logic [9:0] HSyncStart = 10'(`VGA_H_VISIBLE + `VGA_H_FRONT);
    localparam logic [9:0] HSyncEnd   = 10'(`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC);
    localparam logic [9:0] HLast      = 10'(`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC
                                            + `VGA_H_BACK - 1);
    localparam logic [9:0] VVisible   = 10'(`VGA_V_VISIBLE);
    localparam logic [9:0] VSyncStart = 10'(`VGA_V_VISIBLE + `VGA_V_FRONT);
    localparam logic [9:0] VSyncEnd   = 10'(`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC);
    localparam logic [9:0] VLast      = 10'(`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC
                                            + `VGA_V_BACK - 1);

    logic [9:0] hCount;
    logic [9:0] vCount;
    logic       lineDone;

    assign lineDone = (hCount == HLast);

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            hCount <= lineDone ? '0 : hCount + 10'd1;
            // Line advances on the horizontal wrap
            if (lineDone) begin
                vCount <= (vCount == VLast) ? '0 : vCount + 10'd1;
            end
        end
    end

    // ====================
    // Decode, straight from the counters
    // ====================
    always_comb begin
        raster.sync.hSync = !((hCount >= HSyncStart) && (hCount < HSyncEnd));
        raster.sync.vSync = !((vCount >= VSyncStart) && (vCount < VSyncEnd));
        raster.inDisplay  = (hCount < HVisible) && (vCount < VVisible);
        // Pixel pair index, the fetch counters track it
        raster.pixelX     = hCount[9:1];
        raster.lineY      = vCount[8:0];
    end

    // Counters never leave the raster
    a_countRange: assert property (@(posedge clk25) disable iff (!arstN)
        (hCount < `VGA_H_TOTAL) && (vCount < `VGA_V_TOTAL));

endmodule

//--- src/vgaPixelFetch.sv
/*
 * Frame-buffer address generation and pixel bit select
 * Two-stage pipeline with sync and display flag delayed alongside
 */

`timescale 1ns/100ps
`include "vga_macros.svh"

module vgaPixelFetch
    import vgaPkg::*;
(
    input  logic                   clk25,
    input  logic                   arstN,
    input  rasterT                 raster,
    output logic [`VGA_ADDR_W-1:0] pixAddr,
    input  logic [31:0]            pixWord,
    output logic                   pixelOn,
    output rasterT                 rasterOut
);

    localparam int AddrW = `VGA_ADDR_W;
    localparam logic [6:0] LastWord = 7'(`VGA_WORDS_PER_ROW - 1);
    // Syncs inactive, nothing on screen
    localparam rasterT RasterIdle = '{sync: '{hSync: 1'b1, vSync: 1'b1},
                                      inDisplay: 1'b0, pixelX: '0, lineY: '0};

    logic [2:0]       bitCnt;
    logic [6:0]       wordCnt;
    logic             wordDone;
    logic [AddrW-1:0] rowBase;
    logic [AddrW-1:0] nextAddr;
    logic [2:0]       bitQ1, bitQ2;
    logic [1:0]       byteQ1, byteQ2;
    rasterT           rasterQ1, rasterQ2;

    // ====================
    // Offset counters
    // ====================
    assign wordDone = (bitCnt == 3'd7);

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            bitCnt  <= '0;
            wordCnt <= '0;
        end else begin
            // Bit counter parked at zero in blanking
            bitCnt <= raster.inDisplay ? bitCnt + 3'd1 : 3'd0;
            if (wordDone) begin
                wordCnt <= (wordCnt == LastWord) ? '0 : wordCnt + 7'd1;
            end
        end
    end

    // Word row of this line times 80, plus the word offset
    assign rowBase  = AddrW'(raster.lineY[8:2]) * AddrW'(`VGA_WORDS_PER_ROW);
    assign nextAddr = raster.inDisplay ? rowBase + AddrW'(wordCnt) : '0;

    // ====================
    // Stage 1 address, stage 2 select
    // ====================
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            pixAddr  <= '0;
            rasterQ1 <= RasterIdle;
            rasterQ2 <= RasterIdle;
        end else begin
            pixAddr  <= nextAddr;
            rasterQ1 <= raster;
            rasterQ2 <= rasterQ1;
        end
    end

    // Offsets ride along with the read
    always_ff @(posedge clk25) begin
        bitQ1  <= bitCnt;
        byteQ1 <= raster.lineY[1:0];
        bitQ2  <= bitQ1;
        byteQ2 <= byteQ1;
    end

    // Byte lane picks the line, bit picks the pixel
    assign pixelOn   = pixWord[{byteQ2, bitQ2}];
    assign rasterOut = rasterQ2;

    a_addrRange: assert property (@(posedge clk25) disable iff (!arstN)
        pixAddr < `VGA_MEM_WORDS);

    // Counters stay locked to the sync generator's column
    a_columnLock: assert property (@(posedge clk25) disable iff (!arstN)
        raster.inDisplay |-> ({wordCnt, bitCnt[2:1]} == raster.pixelX));

endmodule

//--- src/vgaFrameMem.sv
/*
 * Dual-clock frame buffer
 * Byte-masked core port on CLK_50, read-only pixel port on clk25
 */

`timescale 1ns/100ps
`include "vga_macros.svh"

module vgaFrameMem
    import vgaPkg::*;
(
    input  logic                   CLK_50,
    input  logic                   clk25,
    input  coreReqT                coreReq,
    output logic [31:0]            rspData,
    input  logic [`VGA_ADDR_W-1:0] pixAddr,
    output logic [31:0]            pixWord
);

    logic [31:0]            mem [0:`VGA_MEM_WORDS-1];
    logic [`VGA_ADDR_W-1:0] coreAddr;
    // Core read register, cleared at power-up
    logic [31:0]            coreRdQ = '0;

    // Word index, byte offset dropped
    assign coreAddr = coreReq.address[`VGA_ADDR_W+1:2];

    // ====================
    // Core port
    // ====================
    always_ff @(posedge CLK_50) begin
        if (coreReq.wrEn) begin
            for (int b = 0; b < 4; b++) begin
                // Only enabled lanes change
                if (coreReq.byteEn[b]) begin
                    mem[coreAddr][8*b +: 8] <= coreReq.data[8*b +: 8];
                end
            end
        end
        // Holds until the next read
        if (coreReq.rdEn) begin
            coreRdQ <= mem[coreAddr];
        end
    end

    assign rspData = coreRdQ;

    // ====================
    // Pixel port
    // ====================
    always_ff @(posedge clk25) begin
        pixWord <= mem[pixAddr];
    end

    a_rdWrExclusive: assert property (@(posedge CLK_50)
        !(coreReq.rdEn && coreReq.wrEn));

    // Accesses stay inside the buffer, upper address bits included
    a_coreRange: assert property (@(posedge CLK_50)
        (coreReq.rdEn || coreReq.wrEn) |-> (coreReq.address < 32'(4 * `VGA_MEM_WORDS)));

endmodule

//--- src/vgaCtrl.sv
/*
 * VGA controller top: reset synchronizer, pixel clock divider,
 * sync generator, pixel fetch, frame buffer and output registers
 */

`timescale 1ns/100ps
`include "vga_macros.svh"

module vgaCtrl
    import vgaPkg::*;
(
    input  logic        CLK_50,
    input  logic        arstN,
    input  coreReqT     coreReq,
    output logic [31:0] rspData,
    output rgbT         rgb,
    output syncT        sync
);

    logic [`VGA_RST_SYNC_STAGES-1:0] rstSync;
    logic                            rstN;
    logic                            clk25;
    rasterT                          raster;
    rasterT                          rasterOut;
    logic [`VGA_ADDR_W-1:0]          pixAddr;
    logic [31:0]                     pixWord;
    logic                            pixelOn;
    logic [3:0]                      level;
    rgbT                             nextRgb;

    // ====================
    // Reset and clocks
    // ====================
    // Asserts at once, releases after the last stage
    always_ff @(posedge CLK_50 or negedge arstN) begin
        if (!arstN) begin
            rstSync <= '0;
        end else begin
            rstSync <= {rstSync[`VGA_RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rstN = rstSync[`VGA_RST_SYNC_STAGES-1];

    // Divide by two, stopped low in reset
    always_ff @(posedge CLK_50 or negedge rstN) begin
        if (!rstN) begin
            clk25 <= 1'b0;
        end else begin
            clk25 <= ~clk25;
        end
    end

    // ====================
    // Datapath
    // ====================
    vgaSyncGen i_vgaSyncGen (
        .clk25  (clk25),
        .arstN  (rstN),
        .raster (raster)
    );

    vgaPixelFetch i_vgaPixelFetch (
        .clk25     (clk25),
        .arstN     (rstN),
        .raster    (raster),
        .pixAddr   (pixAddr),
        .pixWord   (pixWord),
        .pixelOn   (pixelOn),
        .rasterOut (rasterOut)
    );

    vgaFrameMem i_vgaFrameMem (
        .CLK_50  (CLK_50),
        .clk25   (clk25),
        .coreReq (coreReq),
        .rspData (rspData),
        .pixAddr (pixAddr),
        .pixWord (pixWord)
    );

    // Set bit is full-scale white, blanking is black
    assign level   = {4{rasterOut.inDisplay & pixelOn}};
    assign nextRgb = '{red: level, green: level, blue: level};

    // Output registers, same delay for colour and syncs
    always_ff @(posedge clk25 or negedge rstN) begin
        if (!rstN) begin
            rgb  <= '0;
            sync <= '1;
        end else begin
            rgb  <= nextRgb;
            sync <= rasterOut.sync;
        end
    end

    // Sync pulses sit in blanking, so the beam is dark there
    a_blankBlack: assert property (@(posedge clk25) disable iff (!rstN)
        (!sync.hSync || !sync.vSync) |-> (rgb == '0));

endmodule

//--- testbench/vgaCtrlTb.sv
/*
 * Testbench for the VGA controller: core port, raster timing, pixel mapping
 */

`timescale 1ns/100ps
`include "vga_macros.svh"

module vgaCtrlTb
    import vgaPkg::*;
();

    // ====================
    // Raster in CLK_50 cycles
    // ====================
    localparam int LineCycles    = 2 * `VGA_H_TOTAL;
    localparam int FrameCycles   = LineCycles * `VGA_V_TOTAL;
    localparam int HSyncCycles   = 2 * `VGA_H_SYNC;
    localparam int VSyncCycles   = LineCycles * `VGA_V_SYNC;
    // Pixel 0 lands this far after the hSync fall
    localparam int FirstPixel    = 2 * (`VGA_H_SYNC + `VGA_H_BACK);
    localparam int PixelEnd      = FirstPixel + 2 * `VGA_H_VISIBLE;
    localparam int FirstLineFall = `VGA_V_SYNC + `VGA_V_BACK;
    // Setup plus two scanned frames, with a frame of margin
    localparam int WatchdogNs    = 3 * FrameCycles * 8;
    localparam syncT SyncIdle    = '{hSync: 1'b1, vSync: 1'b1};
    localparam syncT SyncVFall   = '{hSync: 1'b1, vSync: 1'b0};

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        logic [3:0]  byteEn;
        logic        write;
    } coreOpT;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } probeT;

    // Full-word writes take random data, partial writes the listed data
    localparam int OpCount = 17;
    localparam coreOpT CoreOps [OpCount] = '{
        '{address: 32'h0000_0000, data: 32'h0000_0000, byteEn: 4'hF, write: 1'b1},
        '{address: 32'h0000_0004, data: 32'h0000_0000, byteEn: 4'hF, write: 1'b1},
        '{address: 32'h0000_95FC, data: 32'h0000_0000, byteEn: 4'hF, write: 1'b1},
        '{address: 32'h0000_1000, data: 32'h0000_0000, byteEn: 4'hF, write: 1'b1},
        '{address: 32'h0000_0000, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_0004, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_95FC, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_0000, data: 32'hA5A5_5A5A, byteEn: 4'h5, write: 1'b1},
        '{address: 32'h0000_0004, data: 32'h1234_5678, byteEn: 4'h8, write: 1'b1},
        '{address: 32'h0000_0000, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_0006, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_1000, data: 32'hDEAD_BEEF, byteEn: 4'h6, write: 1'b1},
        '{address: 32'h0000_1000, data: 32'h0000_00C3, byteEn: 4'h1, write: 1'b1},
        '{address: 32'h0000_1003, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_0004, data: 32'hFFFF_FFFF, byteEn: 4'h0, write: 1'b1},
        '{address: 32'h0000_0004, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0},
        '{address: 32'h0000_95FC, data: 32'h0000_0000, byteEn: 4'h0, write: 1'b0}
    };

    // Probe pixels in raster order
    localparam int ProbeCount = 8;
    localparam probeT Probes [ProbeCount] = '{
        '{x: 10'd0,   y: 9'd0},
        '{x: 10'd7,   y: 9'd0},
        '{x: 10'd8,   y: 9'd1},
        '{x: 10'd100, y: 9'd2},
        '{x: 10'd639, y: 9'd3},
        '{x: 10'd320, y: 9'd240},
        '{x: 10'd5,   y: 9'd477},
        '{x: 10'd639, y: 9'd479}
    };

    logic        CLK_50 = 1'b0;
    logic        arstN;
    coreReqT     coreReq;
    logic [31:0] rspData;
    rgbT         rgb;
    syncT        sync;
    logic [31:0] model [0:`VGA_MEM_WORDS-1];
    syncT        lastSync;
    int          cycle;

    always #4 CLK_50 = ~CLK_50;

    vgaCtrl i_vgaCtrl (
        .CLK_50  (CLK_50),
        .arstN   (arstN),
        .coreReq (coreReq),
        .rspData (rspData),
        .rgb     (rgb),
        .sync    (sync)
    );

    // ====================
    // Checks
    // ====================
    task automatic stopRun();
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkRgb(input string name, input rgbT exp, input rgbT act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkSync(input string name, input syncT exp, input syncT act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            stopRun();
        end
    endtask

    // One CLK_50 cycle, outputs sampled mid-cycle
    task automatic stepClk();
        lastSync = sync;
        @(negedge CLK_50);
        cycle++;
    endtask

    task automatic checkResetState(input string name);
        checkRgb({name, " rgb"}, '0, rgb);
        checkSync({name, " sync"}, SyncIdle, sync);
        checkWord({name, " rspData"}, '0, rspData);
    endtask

    // Byte-masked word write into the reference buffer
    function automatic void writeModel(int word, logic [31:0] data, logic [3:0] byteEn);
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                model[word][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Four lines per word row, byte lane by line, bit by column
    function automatic rgbT expectedPixel(int x, int y);
        logic [31:0] word;
        logic        lit;
        rgbT         px;
        word     = model[(y / 4) * `VGA_WORDS_PER_ROW + x / 8];
        lit      = word[(y % 4) * 8 + x % 8];
        px.red   = {4{lit}};
        px.green = {4{lit}};
        px.blue  = {4{lit}};
        return px;
    endfunction

    task automatic applyCoreOp(input coreOpT op, input string name);
        coreReqT req;
        int      word;
        req.address = op.address;
        req.byteEn  = op.byteEn;
        req.data    = (op.write && op.byteEn == 4'hF) ? $urandom() : op.data;
        req.wrEn    = op.write;
        req.rdEn    = !op.write;
        // Byte address to word index
        word        = int'(op.address / 4);
        coreReq     = req;
        if (op.write) begin
            writeModel(word, req.data, req.byteEn);
        end
        stepClk();
        // Read data due one cycle after the strobe
        if (!op.write) begin
            checkWord(name, model[word], rspData);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        int     hFalls;
        int     sinceH;
        int     lastHFall;
        int     vFallCycle;
        int     probeIdx;
        coreOpT fillOp;
        void'($urandom(32'h187a3b04));
        arstN    = 1'b1;
        coreReq  = '0;
        cycle    = 0;
        lastSync = SyncIdle;
        // Synchronizer fills first so the reset pulse gives clean edges
        repeat (6) stepClk();
        arstN = 1'b0;
        repeat (16) begin
            stepClk();
            checkResetState("reset");
        end
        arstN = 1'b1;
        repeat (4) begin
            stepClk();
            checkResetState("after reset");
        end

        for (int i = 0; i < OpCount; i++) begin
            applyCoreOp(CoreOps[i], $sformatf("core op %0d", i));
        end
        // Whole buffer gets random words
        for (int w = 0; w < `VGA_MEM_WORDS; w++) begin
            fillOp.address = 32'(w * 4);
            fillOp.data    = '0;
            fillOp.byteEn  = 4'hF;
            fillOp.write   = 1'b1;
            applyCoreOp(fillOp, "fill");
        end
        coreReq = '0;

        do begin
            stepClk();
        end while (!(lastSync.vSync && !sync.vSync));
        checkSync("sync at vSync fall", SyncVFall, sync);
        vFallCycle = cycle;
        hFalls     = 0;
        sinceH     = 0;
        lastHFall  = cycle;
        probeIdx   = 0;

        // One full frame, vSync fall to vSync fall
        do begin
            stepClk();
            sinceH++;
            if (lastSync.hSync && !sync.hSync) begin
                if (hFalls > 0) begin
                    checkCount("hSync period", LineCycles, cycle - lastHFall);
                end
                hFalls++;
                lastHFall = cycle;
                sinceH    = 0;
            end
            if (!lastSync.hSync && sync.hSync) begin
                checkCount("hSync width", HSyncCycles, cycle - lastHFall);
            end
            if (!lastSync.vSync && sync.vSync) begin
                checkCount("vSync width", VSyncCycles, cycle - vFallCycle);
            end
            if (probeIdx < ProbeCount && hFalls == FirstLineFall + Probes[probeIdx].y
                    && sinceH == FirstPixel + 2 * Probes[probeIdx].x) begin
                checkRgb($sformatf("pixel x=%0d y=%0d", Probes[probeIdx].x, Probes[probeIdx].y),
                         expectedPixel(Probes[probeIdx].x, Probes[probeIdx].y), rgb);
                probeIdx++;
            end else if (hFalls < FirstLineFall || hFalls >= FirstLineFall + `VGA_V_VISIBLE
                    || sinceH < FirstPixel || sinceH >= PixelEnd) begin
                checkRgb("blanking", '0, rgb);
            end
        end while (!(lastSync.vSync && !sync.vSync));
        checkCount("vSync period", FrameCycles, cycle - vFallCycle);
        checkCount("hSync falls per frame", `VGA_V_TOTAL, hFalls);

        if (probeIdx != ProbeCount) begin
            $display("Not every probe pixel was reached during the frame");
            stopRun();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Watchdog expired before the raster checks completed");
        stopRun();
    end

endmodule

//--- vgaCtrl.f
+incdir+src
src/vgaPkg.sv
src/vgaSyncGen.sv
src/vgaPixelFetch.sv
src/vgaFrameMem.sv
src/vgaCtrl.sv
testbench/vgaCtrlTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the vgaCtrl testbench with Verilator and run it
# Exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBin=vgaCtrlSim

verilator --binary --timing --assert -Wno-fatal \
    --top-module vgaCtrlTb -f vgaCtrl.f \
    -Mdir "$buildDir" -o "$simBin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$buildDir/$simBin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation run completed"
exit 0
